//--- rtl/router_pkg.sv
package router_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Default sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int MSG_WIDTH_DEF = 32;  // Payload bits per message
  localparam int N_IN_DEF      = 4;   // Input ports
  localparam int N_OUT_DEF     = 4;   // Output ports

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Route word fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Route word layout, MSB first:
  //   [ input select | output select ]
  // A single port still gets a one bit field so the word never collapses

  // Width of the input select field
  function automatic int in_sel_w(input int n_in);
    int w;
    w = (n_in > 1) ? $clog2(n_in) : 1;
    return w;
  endfunction

  // Width of the output select field
  function automatic int out_sel_w(input int n_out);
    int w;
    w = (n_out > 1) ? $clog2(n_out) : 1;
    return w;
  endfunction

endpackage

//--- rtl/pipe_slice.sv
`timescale 1ns/1ps

// One-entry register slice with valid/ready on both sides.
// Breaks the forward path (msg/val) with a register while ready stays
// combinational, so a full slice still accepts when its entry leaves

module pipe_slice #(
  parameter int WIDTH = router_pkg::MSG_WIDTH_DEF
) (
  input  logic             clk,
  input  logic             reset,

  // Upstream side
  input  logic [WIDTH-1:0] in_msg,
  input  logic             in_val,
  output logic             in_rdy,

  // Downstream side
  output logic [WIDTH-1:0] out_msg,
  output logic             out_val,
  input  logic             out_rdy
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [WIDTH-1:0] msg_q;  // Held message
  logic             full;   // Entry present
  logic             load;   // Upstream transfer this cycle
  logic             drain;  // Downstream transfer this cycle

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign drain  = full & out_rdy;
  assign in_rdy = ~full | out_rdy;  // Room now, or room after this edge
  assign load   = in_val & in_rdy;

  // Full flag
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;             // New entry replaces or fills
    end else if (drain) begin
      full <= 1'b0;
    end
  end

  // Payload register, only written on accept
  always_ff @(posedge clk) begin
    if (load) begin
      msg_q <= in_msg;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign out_msg = msg_q;
  assign out_val = full;

endmodule

//--- rtl/route_switch.sv
`timescale 1ns/1ps

// Route register plus a single-path crossbar.
// One input is steered to one output; every other port sits idle.
// The two override pins from the serial bridge pull a select to port 0

module route_switch #(
  parameter  int MSG_WIDTH = router_pkg::MSG_WIDTH_DEF,
  parameter  int N_IN      = router_pkg::N_IN_DEF,
  parameter  int N_OUT     = router_pkg::N_OUT_DEF,
  localparam int IN_W      = router_pkg::in_sel_w(N_IN),
  localparam int OUT_W     = router_pkg::out_sel_w(N_OUT),
  localparam int ROUTE_W   = IN_W + OUT_W
) (
  input  logic                 clk,
  input  logic                 reset,

  // From the input slices
  input  logic [MSG_WIDTH-1:0] in_msg[N_IN],
  input  logic                 in_val[N_IN],
  output logic                 in_rdy[N_IN],

  // To the output slices
  output logic [MSG_WIDTH-1:0] out_msg[N_OUT],
  output logic                 out_val[N_OUT],
  input  logic                 out_rdy[N_OUT],

  // Route configuration
  input  logic [ROUTE_W-1:0]   route,
  input  logic                 route_val,
  output logic                 route_rdy,

  // Maintenance overrides
  input  logic                 input_spi,
  input  logic                 output_spi
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Route register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [ROUTE_W-1:0] route_q;

  // Always accepting, a write takes effect from the next edge
  assign route_rdy = 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      route_q <= '0;  // Input 0 to output 0
    end else if (route_val) begin
      route_q <= route;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Select decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [IN_W-1:0]  route_in_sel;   // Stored input field
  logic [OUT_W-1:0] route_out_sel;  // Stored output field
  logic [IN_W-1:0]  in_sel;         // Effective input select
  logic [OUT_W-1:0] out_sel;        // Effective output select

  assign route_in_sel  = route_q[ROUTE_W-1 -: IN_W];  // Upper field
  assign route_out_sel = route_q[OUT_W-1:0];          // Lower field

  // Overrides act in the same cycle and are independent of each other
  assign in_sel  = input_spi  ? '0 : route_in_sel;
  assign out_sel = output_spi ? '0 : route_out_sel;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Crossbar
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [MSG_WIDTH-1:0] sel_msg;  // Message of the chosen input
  logic                 sel_val;  // Valid of the chosen input
  logic                 sel_rdy;  // Ready of the chosen output

  // Input mux, a select past the last port gives no path
  always_comb begin
    sel_msg = '0;
    sel_val = 1'b0;
    for (int i = 0; i < N_IN; i++) begin
      if (int'(in_sel) == i) begin
        sel_msg = in_msg[i];
        sel_val = in_val[i];
      end
    end
  end

  // Ready mux from the chosen output
  always_comb begin
    sel_rdy = 1'b0;
    for (int o = 0; o < N_OUT; o++) begin
      if (int'(out_sel) == o) begin
        sel_rdy = out_rdy[o];
      end
    end
  end

  // Forward steering; idle outputs carry zero
  always_comb begin
    for (int o = 0; o < N_OUT; o++) begin
      if (int'(out_sel) == o) begin
        out_msg[o] = sel_msg;
        out_val[o] = sel_val;
      end else begin
        out_msg[o] = '0;
        out_val[o] = 1'b0;
      end
    end
  end

  // Backward steering of ready
  always_comb begin
    for (int i = 0; i < N_IN; i++) begin
      in_rdy[i] = (int'(in_sel) == i) ? sel_rdy : 1'b0;
    end
  end

endmodule

//--- rtl/msg_router.sv
`timescale 1ns/1ps

// Message router top.
// recv ports -> input slices -> route switch -> output slices -> send ports.
// Zero back-pressure latency from recv accept to send_val is two cycles

module msg_router #(
  parameter  int MSG_WIDTH = router_pkg::MSG_WIDTH_DEF,
  parameter  int N_IN      = router_pkg::N_IN_DEF,
  parameter  int N_OUT     = router_pkg::N_OUT_DEF,
  localparam int ROUTE_W   = router_pkg::in_sel_w(N_IN) + router_pkg::out_sel_w(N_OUT)
) (
  input  logic                 clk,
  input  logic                 reset,

  // Outside inputs
  input  logic [MSG_WIDTH-1:0] recv_msg[N_IN],
  input  logic                 recv_val[N_IN],
  output logic                 recv_rdy[N_IN],

  // Outside outputs
  output logic [MSG_WIDTH-1:0] send_msg[N_OUT],
  output logic                 send_val[N_OUT],
  input  logic                 send_rdy[N_OUT],

  // Route word, input select in the upper field
  input  logic [ROUTE_W-1:0]   route,
  input  logic                 route_val,
  output logic                 route_rdy,

  // Serial bridge overrides
  input  logic                 input_spi,
  input  logic                 output_spi
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Internal wires
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Input slices to switch
  logic [MSG_WIDTH-1:0] sw_in_msg[N_IN];
  logic                 sw_in_val[N_IN];
  logic                 sw_in_rdy[N_IN];

  // Switch to output slices
  logic [MSG_WIDTH-1:0] sw_out_msg[N_OUT];
  logic                 sw_out_val[N_OUT];
  logic                 sw_out_rdy[N_OUT];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < N_IN; i++) begin : g_in
    pipe_slice #(
      .WIDTH (MSG_WIDTH)
    ) u_in_slice (
      .clk     (clk),
      .reset   (reset),
      .in_msg  (recv_msg[i]),
      .in_val  (recv_val[i]),
      .in_rdy  (recv_rdy[i]),
      .out_msg (sw_in_msg[i]),
      .out_val (sw_in_val[i]),
      .out_rdy (sw_in_rdy[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Route switch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  route_switch #(
    .MSG_WIDTH (MSG_WIDTH),
    .N_IN      (N_IN),
    .N_OUT     (N_OUT)
  ) u_switch (
    .clk        (clk),
    .reset      (reset),
    .in_msg     (sw_in_msg),
    .in_val     (sw_in_val),
    .in_rdy     (sw_in_rdy),
    .out_msg    (sw_out_msg),
    .out_val    (sw_out_val),
    .out_rdy    (sw_out_rdy),
    .route      (route),
    .route_val  (route_val),
    .route_rdy  (route_rdy),
    .input_spi  (input_spi),   // Forces input 0
    .output_spi (output_spi)   // Forces output 0
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar o = 0; o < N_OUT; o++) begin : g_out
    pipe_slice #(
      .WIDTH (MSG_WIDTH)
    ) u_out_slice (
      .clk     (clk),
      .reset   (reset),
      .in_msg  (sw_out_msg[o]),
      .in_val  (sw_out_val[o]),
      .in_rdy  (sw_out_rdy[o]),
      .out_msg (send_msg[o]),
      .out_val (send_val[o]),
      .out_rdy (send_rdy[o])
    );
  end

endmodule

//--- testbench/msg_router_chk.sv
`timescale 1ns/1ps

// Structural rules of the route switch, bound into every route_switch.
// The live path is worked out from the route port and the override pins alone

module msg_router_chk #(
  parameter int N_IN  = router_pkg::N_IN_DEF,
  parameter int N_OUT = router_pkg::N_OUT_DEF,
  parameter int IN_W  = router_pkg::in_sel_w(router_pkg::N_IN_DEF),
  parameter int OUT_W = router_pkg::out_sel_w(router_pkg::N_OUT_DEF)
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  in_val[N_IN],
  input logic                  in_rdy[N_IN],
  input logic                  out_val[N_OUT],
  input logic                  out_rdy[N_OUT],
  input logic [IN_W+OUT_W-1:0] route,
  input logic                  route_val,
  input logic                  input_spi,
  input logic                  output_spi
);

  logic [IN_W+OUT_W-1:0] route_seen;  // Last route word written
  int                    path_in;     // Input the live path starts at
  int                    path_out;    // Output it ends at
  logic [N_OUT-1:0]      val_vec;     // Output valids, packed
  logic [N_IN-1:0]       stray_rdy;   // Ready on an input off the path
  logic [N_OUT-1:0]      stray_val;   // Valid on an output off the path
  logic                  hi_rdy;      // Any ready above input 0
  logic                  hi_val;      // Any valid above output 0
  logic                  fwd_ok;      // Path valid matches its source
  logic                  bwd_ok;      // Path ready matches its sink

  // Route as seen on the port, zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      route_seen <= '0;
    end else if (route_val) begin
      route_seen <= route;
    end
  end

  always_comb begin
    path_in  = input_spi  ? 0 : int'(route_seen[IN_W+OUT_W-1 -: IN_W]);
    path_out = output_spi ? 0 : int'(route_seen[OUT_W-1:0]);
  end

  always_comb begin
    hi_val = 1'b0;
    for (int o = 0; o < N_OUT; o++) begin
      val_vec[o]   = out_val[o];
      stray_val[o] = out_val[o] && (o != path_out);
      if (o > 0) begin
        hi_val = hi_val | out_val[o];
      end
    end
  end

  always_comb begin
    hi_rdy = 1'b0;
    for (int i = 0; i < N_IN; i++) begin
      stray_rdy[i] = in_rdy[i] && (i != path_in);
      if (i > 0) begin
        hi_rdy = hi_rdy | in_rdy[i];
      end
    end
  end

  always_comb begin
    fwd_ok = 1'b1;
    bwd_ok = 1'b1;
    for (int i = 0; i < N_IN; i++) begin
      for (int o = 0; o < N_OUT; o++) begin
        if (i == path_in && o == path_out) begin
          fwd_ok = (out_val[o] == in_val[i]);
          bwd_ok = (in_rdy[i] == out_rdy[o]);
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Single path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_one_path: assert property (@(posedge clk) disable iff (reset)
    $countones(val_vec) <= 1)
    else $error("More than one switch output is valid in the same cycle");

  a_idle_rdy: assert property (@(posedge clk) disable iff (reset)
    stray_rdy == '0)
    else $error("An unselected switch input sees ready high");

  a_idle_val: assert property (@(posedge clk) disable iff (reset)
    stray_val == '0)
    else $error("An unselected switch output is valid");

  a_fwd_path: assert property (@(posedge clk) disable iff (reset)
    fwd_ok)
    else $error("Selected output valid does not follow the selected input");

  a_bwd_path: assert property (@(posedge clk) disable iff (reset)
    bwd_ok)
    else $error("Selected input ready does not follow the selected output");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Override selects
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_in_force: assert property (@(posedge clk) disable iff (reset)
    input_spi |-> !hi_rdy)
    else $error("input_spi high but an input other than port 0 sees ready");

  a_out_force: assert property (@(posedge clk) disable iff (reset)
    output_spi |-> !hi_val)
    else $error("output_spi high but an output other than port 0 is valid");

endmodule

bind route_switch msg_router_chk #(
  .N_IN  (N_IN),
  .N_OUT (N_OUT),
  .IN_W  (IN_W),
  .OUT_W (OUT_W)
) u_chk (
  .clk        (clk),
  .reset      (reset),
  .in_val     (in_val),
  .in_rdy     (in_rdy),
  .out_val    (out_val),
  .out_rdy    (out_rdy),
  .route      (route),
  .route_val  (route_val),
  .input_spi  (input_spi),
  .output_spi (output_spi)
);

//--- testbench/msg_router_tb.sv
`timescale 1ns/1ps

module msg_router_tb;

  localparam int MSG_WIDTH      = router_pkg::MSG_WIDTH_DEF;
  localparam int N_IN           = router_pkg::N_IN_DEF;
  localparam int N_OUT          = router_pkg::N_OUT_DEF;
  localparam int IN_W           = router_pkg::in_sel_w(N_IN);
  localparam int OUT_W          = router_pkg::out_sel_w(N_OUT);
  localparam int ROUTE_W        = IN_W + OUT_W;
  localparam int TIMEOUT_CYCLES = 4000;  // About twice the cycles all tests need

  logic                 clk = 1'b0;
  logic                 reset;
  logic [MSG_WIDTH-1:0] recv_msg[N_IN];
  logic                 recv_val[N_IN];
  logic                 recv_rdy[N_IN];
  logic [MSG_WIDTH-1:0] send_msg[N_OUT];
  logic                 send_val[N_OUT];
  logic                 send_rdy[N_OUT];
  logic [ROUTE_W-1:0]   route;
  logic                 route_val;
  logic                 route_rdy;
  logic                 input_spi;
  logic                 output_spi;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [MSG_WIDTH-1:0] ref_q[N_OUT][$];  // Expected messages per output
  int                   acc_q[N_OUT][$];  // Acceptance cycle of each one
  logic [ROUTE_W-1:0]   model_route;
  int                   cycle = 0;
  bit                   stall_mode = 1'b0;
  string                test_name = "reset";

  always #50 clk = ~clk;

  msg_router #(
    .MSG_WIDTH (MSG_WIDTH),
    .N_IN      (N_IN),
    .N_OUT     (N_OUT)
  ) u_msg_router (
    .clk        (clk),
    .reset      (reset),
    .recv_msg   (recv_msg),
    .recv_val   (recv_val),
    .recv_rdy   (recv_rdy),
    .send_msg   (send_msg),
    .send_val   (send_val),
    .send_rdy   (send_rdy),
    .route      (route),
    .route_val  (route_val),
    .route_rdy  (route_rdy),
    .input_spi  (input_spi),
    .output_spi (output_spi)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped");
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int o = 0; o < N_OUT; o++) begin
      n += ref_q[o].size();
    end
    return n;
  endfunction

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout after %0d cycles, %0d messages still expected",
                                  cycle, pending()));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitor and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin : monitor
    int                   in_sel;
    int                   out_sel;
    int                   exp_cyc;
    logic [MSG_WIDTH-1:0] exp_msg;
    if (reset) begin
      model_route = '0;  // Input 0 to output 0
    end else begin
      in_sel  = input_spi  ? 0 : int'(model_route[ROUTE_W-1 -: IN_W]);
      out_sel = output_spi ? 0 : int'(model_route[OUT_W-1:0]);
      if (recv_val[in_sel] && recv_rdy[in_sel]) begin
        ref_q[out_sel].push_back(recv_msg[in_sel]);
        acc_q[out_sel].push_back(cycle);
      end
      // Without stalls the path takes one message every cycle
      if (!stall_mode && recv_val[in_sel]) begin
        assert (recv_rdy[in_sel])
          else stop_with_failure($sformatf("Input %0d refused a message with no stall", in_sel));
      end
      for (int o = 0; o < N_OUT; o++) begin
        if (send_val[o] && send_rdy[o]) begin
          if (ref_q[o].size() == 0) begin
            stop_with_failure($sformatf("Output %0d sent a message never routed to it", o));
          end else begin
            exp_msg = ref_q[o].pop_front();
            exp_cyc = acc_q[o].pop_front();
            assert (send_msg[o] == exp_msg)
              else stop_with_failure($sformatf("Fail %s out%0d expected %h actual %h",
                                               test_name, o, exp_msg, send_msg[o]));
            if (!stall_mode) begin
              assert (cycle - exp_cyc == 2)
                else stop_with_failure($sformatf("Fail %s latency expected 2 actual %0d",
                                                 test_name, cycle - exp_cyc));
            end
          end
        end
      end
      if (route_val) begin
        assert (route_rdy) else stop_with_failure("route_rdy was low during a route write");
        model_route = route;  // Steers from the next edge
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Output back-pressure, random only in stall mode
  initial begin : stall_drive
    for (int o = 0; o < N_OUT; o++) begin
      send_rdy[o] = 1'b1;
    end
    forever begin
      @(negedge clk);
      for (int o = 0; o < N_OUT; o++) begin
        send_rdy[o] = stall_mode ? (($urandom % 3) != 0) : 1'b1;
      end
    end
  end

  task automatic write_route(input int in_port, input int out_port);
    route     = {IN_W'(in_port), OUT_W'(out_port)};
    route_val = 1'b1;
    @(negedge clk);
    route_val = 1'b0;
  endtask

  // Offers count messages on one port; each is held until accepted
  task automatic offer_messages(input int port, input int count, input bit gaps);
    for (int n = 0; n < count; n++) begin
      recv_msg[port] = MSG_WIDTH'($urandom);
      recv_val[port] = 1'b1;
      do @(posedge clk); while (!recv_rdy[port]);
      @(negedge clk);
      recv_val[port] = 1'b0;
      if (gaps && ($urandom % 4 == 0)) begin
        @(negedge clk);
      end
    end
  endtask

  task automatic wait_for_drain();
    while (pending() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic steer_and_drain(input int in_port, input int out_port, input int count);
    write_route(in_port, out_port);
    offer_messages(in_port, count, 1'b1);
    wait_for_drain();
  endtask

  initial begin : stimulus
    void'($urandom(38));
    reset      = 1'b1;
    route      = '0;
    route_val  = 1'b0;
    input_spi  = 1'b0;
    output_spi = 1'b0;
    for (int i = 0; i < N_IN; i++) begin
      recv_msg[i] = '0;
      recv_val[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_name = "reset_route";
    for (int o = 0; o < N_OUT; o++) begin
      assert (!send_val[o]) else stop_with_failure($sformatf("send_val %0d high after reset", o));
    end
    offer_messages(0, 16, 1'b1);
    wait_for_drain();

    test_name = "route_write";
    steer_and_drain(1, 2, 12);
    steer_and_drain(3, 1, 12);
    steer_and_drain(2, 3, 12);
    steer_and_drain(0, 1, 12);

    test_name = "override";
    write_route(2, 3);
    input_spi = 1'b1;           // Input 0 to output 3
    offer_messages(0, 10, 1'b1);
    wait_for_drain();
    input_spi  = 1'b0;
    output_spi = 1'b1;          // Input 2 to output 0
    offer_messages(2, 10, 1'b1);
    wait_for_drain();
    input_spi = 1'b1;           // Both forced
    offer_messages(0, 10, 1'b1);
    wait_for_drain();
    input_spi  = 1'b0;
    output_spi = 1'b0;

    test_name = "random_stall";
    write_route(3, 2);
    stall_mode = 1'b1;
    offer_messages(3, 700, 1'b1);
    wait_for_drain();
    stall_mode = 1'b0;
    repeat (2) @(negedge clk);

    test_name = "full_rate";
    write_route(1, 3);
    offer_messages(1, 400, 1'b0);

    repeat (4) @(negedge clk);  // Last message is two edges out, so all have left by now
    if (pending() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d messages never left the router", pending()));
    end
  end

endmodule

//--- msg_router.f
rtl/router_pkg.sv
rtl/pipe_slice.sv
rtl/route_switch.sv
rtl/msg_router.sv
testbench/msg_router_chk.sv
testbench/msg_router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the msg_router testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing run fails the script.

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -j 0 \
    --top-module msg_router_tb \
    -f msg_router.f \
    -o msg_router_sim &&
  ./obj_dir/msg_router_sim ||
  {
    echo "msg_router simulation did not pass"
    exit 1
  }
